/* logic/csr_pkg.sv */
`default_nettype none

package csr_pkg;

   localparam int CSR_ADDR_W = 12;

   typedef logic [CSR_ADDR_W-1:0] csr_addr_t;

   // ***********************************************************
   // csr identity
   // ***********************************************************

   // every member value is the address of that csr
   typedef enum logic [CSR_ADDR_W-1:0] {
      CSR_NONE          = 12'h000,
      // machine trap setup and counter control
      CSR_MSTATUS       = 12'h300,
      CSR_MISA          = 12'h301,
      CSR_MIE           = 12'h304,
      CSR_MTVEC         = 12'h305,
      CSR_MCOUNTINHIBIT = 12'h320,
      CSR_MHPME3        = 12'h323,
      CSR_MHPME4        = 12'h324,
      CSR_MHPME5        = 12'h325,
      CSR_MHPME6        = 12'h326,
      // machine trap handling
      CSR_MSCRATCH      = 12'h340,
      CSR_MEPC          = 12'h341,
      CSR_MCAUSE        = 12'h342,
      CSR_MTVAL         = 12'h343,
      CSR_MIP           = 12'h344,
      // trigger and debug
      CSR_MTSEL         = 12'h7A0,
      CSR_MTDATA1       = 12'h7A1,
      CSR_MTDATA2       = 12'h7A2,
      CSR_DCSR          = 12'h7B0,
      CSR_DPC           = 12'h7B1,
      // region access, debug state and icache access
      CSR_MRAC          = 12'h7C0,
      CSR_DMST          = 12'h7C4,
      CSR_DICAWICS      = 12'h7C8,
      CSR_DICAD0        = 12'h7C9,
      CSR_DICAD1        = 12'h7CA,
      CSR_DICAGO        = 12'h7CB,
      CSR_DICAD0H       = 12'h7CC,
      // internal timers
      CSR_MITCNT0       = 12'h7D2,
      CSR_MITB0         = 12'h7D3,
      CSR_MITCTL0       = 12'h7D4,
      CSR_MITCNT1       = 12'h7D5,
      CSR_MITB1         = 12'h7D6,
      CSR_MITCTL1       = 12'h7D7,
      // core control
      CSR_MCGC          = 12'h7F8,
      CSR_MFDC          = 12'h7F9,
      CSR_MSCAUSE       = 12'h7FF,
      // machine counters
      CSR_MCYCLEL       = 12'hB00,
      CSR_MINSTRETL     = 12'hB02,
      CSR_MHPMC3        = 12'hB03,
      CSR_MHPMC4        = 12'hB04,
      CSR_MHPMC5        = 12'hB05,
      CSR_MHPMC6        = 12'hB06,
      CSR_MCYCLEH       = 12'hB80,
      CSR_MINSTRETH     = 12'hB82,
      CSR_MHPMC3H       = 12'hB83,
      CSR_MHPMC4H       = 12'hB84,
      CSR_MHPMC5H       = 12'hB85,
      CSR_MHPMC6H       = 12'hB86,
      // external interrupt controller
      CSR_MEIVT         = 12'hBC8,
      CSR_MEIPT         = 12'hBC9,
      CSR_MEICPCT       = 12'hBCA,
      CSR_MEICIDPL      = 12'hBCB,
      CSR_MEICURPL      = 12'hBCC,
      // machine information and read-only status
      CSR_MVENDORID     = 12'hF11,
      CSR_MARCHID       = 12'hF12,
      CSR_MIMPID        = 12'hF13,
      CSR_MHARTID       = 12'hF14,
      CSR_MDSEAC        = 12'hFC0,
      CSR_MEIHAP        = 12'hFC8
   } csr_id_e;

   // ***********************************************************
   // attribute classes
   // ***********************************************************
   // read-only     mvendorid marchid mimpid mhartid mdseac meihap
   // debug-only    dcsr dpc dmst dicawics dicad0 dicad0h dicad1 dicago
   // timer         mitcnt0 mitcnt1 mitb0 mitb1 mitctl0 mitctl1
   // fast-redirect meicpct
   // pre-sync      mfdc mcountinhibit mhpme3..6 mcyclel mcycleh
   //               minstretl minstreth
   // post-sync     mfdc mstatus mtvec mepc mtdata1 mtdata2 dcsr mrac

   localparam int PRESYNC_N  = 10;
   localparam int POSTSYNC_N = 8;

   localparam csr_id_e PRESYNC_LIST [PRESYNC_N] = '{
      CSR_MFDC,
      CSR_MCOUNTINHIBIT,
      CSR_MHPME3,
      CSR_MHPME4,
      CSR_MHPME5,
      CSR_MHPME6,
      CSR_MCYCLEL,
      CSR_MCYCLEH,
      CSR_MINSTRETL,
      CSR_MINSTRETH
   };

   localparam csr_id_e POSTSYNC_LIST [POSTSYNC_N] = '{
      CSR_MFDC,
      CSR_MSTATUS,
      CSR_MTVEC,
      CSR_MEPC,
      CSR_MTDATA1,
      CSR_MTDATA2,
      CSR_DCSR,
      CSR_MRAC
   };

endpackage

`default_nettype wire

/* logic/csr_addr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_addr_decode (
   input  csr_pkg::csr_addr_t csr_addr,
   output csr_pkg::csr_id_e   csr_id,
   output logic               is_read_only,
   output logic               is_debug_only,
   output logic               is_timer,
   output logic               is_fast_redirect,
   output logic               needs_presync,
   output logic               needs_postsync
);

   // ***********************************************************
   // address table
   // ***********************************************************

   always_comb begin
      csr_id           = csr_pkg::CSR_NONE;
      is_read_only     = 1'b0;
      is_debug_only    = 1'b0;
      is_timer         = 1'b0;
      is_fast_redirect = 1'b0;
      needs_presync    = 1'b0;
      needs_postsync   = 1'b0;

      case (csr_addr)
         // plain read/write csrs with no special handling
         csr_pkg::CSR_MISA,
         csr_pkg::CSR_MIE,
         csr_pkg::CSR_MSCRATCH,
         csr_pkg::CSR_MCAUSE,
         csr_pkg::CSR_MTVAL,
         csr_pkg::CSR_MIP,
         csr_pkg::CSR_MTSEL,
         csr_pkg::CSR_MCGC,
         csr_pkg::CSR_MSCAUSE,
         csr_pkg::CSR_MHPMC3,
         csr_pkg::CSR_MHPMC4,
         csr_pkg::CSR_MHPMC5,
         csr_pkg::CSR_MHPMC6,
         csr_pkg::CSR_MHPMC3H,
         csr_pkg::CSR_MHPMC4H,
         csr_pkg::CSR_MHPMC5H,
         csr_pkg::CSR_MHPMC6H,
         csr_pkg::CSR_MEIVT,
         csr_pkg::CSR_MEIPT,
         csr_pkg::CSR_MEICIDPL,
         csr_pkg::CSR_MEICURPL: begin
            csr_id = csr_pkg::csr_id_e'(csr_addr);
         end

         // writes here change fetch or trap behavior
         csr_pkg::CSR_MSTATUS,
         csr_pkg::CSR_MTVEC,
         csr_pkg::CSR_MEPC,
         csr_pkg::CSR_MTDATA1,
         csr_pkg::CSR_MTDATA2,
         csr_pkg::CSR_MRAC: begin
            csr_id         = csr_pkg::csr_id_e'(csr_addr);
            needs_postsync = 1'b1;
         end

         // counter reads must see all older instructions retired
         csr_pkg::CSR_MCOUNTINHIBIT,
         csr_pkg::CSR_MHPME3,
         csr_pkg::CSR_MHPME4,
         csr_pkg::CSR_MHPME5,
         csr_pkg::CSR_MHPME6,
         csr_pkg::CSR_MCYCLEL,
         csr_pkg::CSR_MCYCLEH,
         csr_pkg::CSR_MINSTRETL,
         csr_pkg::CSR_MINSTRETH: begin
            csr_id        = csr_pkg::csr_id_e'(csr_addr);
            needs_presync = 1'b1;
         end

         // feature disables touch the whole pipe
         csr_pkg::CSR_MFDC: begin
            csr_id         = csr_pkg::CSR_MFDC;
            needs_presync  = 1'b1;
            needs_postsync = 1'b1;
         end

         csr_pkg::CSR_DCSR: begin
            csr_id         = csr_pkg::CSR_DCSR;
            is_debug_only  = 1'b1;
            needs_postsync = 1'b1;
         end

         csr_pkg::CSR_DPC,
         csr_pkg::CSR_DMST,
         csr_pkg::CSR_DICAWICS,
         csr_pkg::CSR_DICAD0,
         csr_pkg::CSR_DICAD0H,
         csr_pkg::CSR_DICAD1,
         csr_pkg::CSR_DICAGO: begin
            csr_id        = csr_pkg::csr_id_e'(csr_addr);
            is_debug_only = 1'b1;
         end

         csr_pkg::CSR_MITCNT0,
         csr_pkg::CSR_MITB0,
         csr_pkg::CSR_MITCTL0,
         csr_pkg::CSR_MITCNT1,
         csr_pkg::CSR_MITB1,
         csr_pkg::CSR_MITCTL1: begin
            csr_id   = csr_pkg::csr_id_e'(csr_addr);
            is_timer = 1'b1;
         end

         // claim pointer is bypassed when fast redirect is built in
         csr_pkg::CSR_MEICPCT: begin
            csr_id           = csr_pkg::CSR_MEICPCT;
            is_fast_redirect = 1'b1;
         end

         csr_pkg::CSR_MVENDORID,
         csr_pkg::CSR_MARCHID,
         csr_pkg::CSR_MIMPID,
         csr_pkg::CSR_MHARTID,
         csr_pkg::CSR_MDSEAC,
         csr_pkg::CSR_MEIHAP: begin
            csr_id       = csr_pkg::csr_id_e'(csr_addr);
            is_read_only = 1'b1;
         end

         default: begin
            csr_id = csr_pkg::CSR_NONE;
         end
      endcase
   end

endmodule

`default_nettype wire

/* logic/csr_access_check.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_access_check #(
   parameter int TIMER_EN          = 1,
   parameter int FAST_INT_REDIRECT = 1
) (
   input  logic             clk,
   input  logic             reset,
   input  logic             csr_req,
   input  logic             csr_wen,
   input  logic             dbg_halted,
   input  csr_pkg::csr_id_e csr_id,
   input  logic             is_read_only,
   input  logic             is_debug_only,
   input  logic             is_timer,
   input  logic             is_fast_redirect,
   input  logic             needs_presync,
   input  logic             needs_postsync,
   output logic             rsp_valid,
   output logic             csr_legal,
   output logic             presync,
   output logic             postsync,
   output csr_pkg::csr_id_e rsp_id
);

   localparam logic TIMER_OFF    = (TIMER_EN == 0);
   localparam logic FAST_RDR_ON  = (FAST_INT_REDIRECT != 0);

   logic             known_csr;
   logic             mode_ok;
   logic             cfg_illegal;
   logic             ro_write;
   logic             legal_d;
   logic             presync_d;
   logic             postsync_d;
   csr_pkg::csr_id_e id_d;

   // ***********************************************************
   // legality
   // ***********************************************************

   assign known_csr = (csr_id != csr_pkg::CSR_NONE);

   // debug csrs are only reachable from halted state
   assign mode_ok = ~is_debug_only | dbg_halted;

   // features removed by build configuration
   assign cfg_illegal = (is_timer & TIMER_OFF) | (is_fast_redirect & FAST_RDR_ON);

   assign ro_write = csr_wen & is_read_only;

   assign legal_d = csr_req & known_csr & mode_ok & ~cfg_illegal & ~ro_write;

   // ***********************************************************
   // sync qualification
   // ***********************************************************

   // a write has nothing older to wait for before reading
   assign presync_d  = csr_req & needs_presync & ~csr_wen;
   assign postsync_d = csr_req & needs_postsync;

   assign id_d = csr_req ? csr_id : csr_pkg::CSR_NONE;

   // ***********************************************************
   // result register
   // ***********************************************************

   always_ff @(posedge clk) begin
      if (reset) begin
         rsp_valid <= 1'b0;
         csr_legal <= 1'b0;
         presync   <= 1'b0;
         postsync  <= 1'b0;
         rsp_id    <= csr_pkg::CSR_NONE;
      end else begin
         rsp_valid <= csr_req;
         csr_legal <= legal_d;
         presync   <= presync_d;
         postsync  <= postsync_d;
         rsp_id    <= id_d;
      end
   end

endmodule

`default_nettype wire

/* logic/csr_decode_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode_unit #(
   parameter int TIMER_EN          = 1,
   parameter int FAST_INT_REDIRECT = 1
) (
   input  logic               clk,
   input  logic               reset,
   input  logic               csr_req,
   input  logic               csr_wen,
   input  logic               dbg_halted,
   input  csr_pkg::csr_addr_t csr_addr,
   output logic               rsp_valid,
   output logic               csr_legal,
   output logic               presync,
   output logic               postsync,
   output csr_pkg::csr_id_e   rsp_id
);

   csr_pkg::csr_id_e csr_id;
   logic             is_read_only;
   logic             is_debug_only;
   logic             is_timer;
   logic             is_fast_redirect;
   logic             needs_presync;
   logic             needs_postsync;

   // address lookup, same cycle as the request
   csr_addr_decode i_addr_decode (
      .csr_addr         (csr_addr),
      .csr_id           (csr_id),
      .is_read_only     (is_read_only),
      .is_debug_only    (is_debug_only),
      .is_timer         (is_timer),
      .is_fast_redirect (is_fast_redirect),
      .needs_presync    (needs_presync),
      .needs_postsync   (needs_postsync)
   );

   // qualification and one-cycle result stage
   csr_access_check #(
      .TIMER_EN          (TIMER_EN),
      .FAST_INT_REDIRECT (FAST_INT_REDIRECT)
   ) i_access_check (
      .clk              (clk),
      .reset            (reset),
      .csr_req          (csr_req),
      .csr_wen          (csr_wen),
      .dbg_halted       (dbg_halted),
      .csr_id           (csr_id),
      .is_read_only     (is_read_only),
      .is_debug_only    (is_debug_only),
      .is_timer         (is_timer),
      .is_fast_redirect (is_fast_redirect),
      .needs_presync    (needs_presync),
      .needs_postsync   (needs_postsync),
      .rsp_valid        (rsp_valid),
      .csr_legal        (csr_legal),
      .presync          (presync),
      .postsync         (postsync),
      .rsp_id           (rsp_id)
   );

endmodule

`default_nettype wire

/* test/csr_decode_sva.sv */
`timescale 1ns/1ps
`default_nettype none

module csr_decode_sva (
   input logic             clk,
   input logic             reset,
   input logic             csr_req,
   input logic             csr_wen,
   input logic             rsp_valid,
   input logic             csr_legal,
   input logic             presync,
   input logic             postsync,
   input csr_pkg::csr_id_e rsp_id
);

   // one response per strobe, one cycle later
   valid_follows_req: assert property (@(posedge clk) disable iff (reset)
      rsp_valid == $past(csr_req))
      else $error("response valid does not follow the request strobe");

   legal_needs_valid: assert property (@(posedge clk) disable iff (reset)
      csr_legal |-> rsp_valid)
      else $error("legal flag raised without a response");

   sync_needs_valid: assert property (@(posedge clk) disable iff (reset)
      (presync || postsync) |-> rsp_valid)
      else $error("sync flag raised without a response");

   legal_needs_known_id: assert property (@(posedge clk) disable iff (reset)
      csr_legal |-> (rsp_id != csr_pkg::CSR_NONE))
      else $error("legal flag raised for an unknown csr");

   // writes never wait for older instructions
   presync_only_on_read: assert property (@(posedge clk) disable iff (reset)
      presync |-> !$past(csr_wen))
      else $error("pre-sync raised for a write access");

endmodule

bind csr_decode_unit csr_decode_sva i_sva (
   .clk       (clk),
   .reset     (reset),
   .csr_req   (csr_req),
   .csr_wen   (csr_wen),
   .rsp_valid (rsp_valid),
   .csr_legal (csr_legal),
   .presync   (presync),
   .postsync  (postsync),
   .rsp_id    (rsp_id)
);

`default_nettype wire

/* include/csr_expect.svh */
`ifndef CSR_EXPECT_SVH
`define CSR_EXPECT_SVH
`default_nettype none

// configuration of the DUT as built in the testbench
localparam int EXP_TIMER_EN          = 1;
localparam int EXP_FAST_INT_REDIRECT = 1;

// expected result of one access
function automatic void csr_expect(
   input  csr_pkg::csr_addr_t addr,
   input  logic               wen,
   input  logic               halted,
   output csr_pkg::csr_id_e   id,
   output logic               legal,
   output logic               pre,
   output logic               post
);
   csr_pkg::csr_id_e e;
   logic             ro;
   logic             dbg;
   logic             tmr;
   logic             fast;
   id   = csr_pkg::CSR_NONE;
   pre  = 1'b0;
   post = 1'b0;
   e    = e.first();
   // an address is kept only if some enum member carries it
   for (int i = 0; i < e.num(); i++) begin
      if (e != csr_pkg::CSR_NONE && csr_pkg::csr_addr_t'(e) == addr) begin
         id = e;
      end
      e = e.next();
   end
   ro   = id inside {csr_pkg::CSR_MVENDORID, csr_pkg::CSR_MARCHID, csr_pkg::CSR_MIMPID,
                     csr_pkg::CSR_MHARTID, csr_pkg::CSR_MDSEAC, csr_pkg::CSR_MEIHAP};
   dbg  = id inside {csr_pkg::CSR_DCSR, csr_pkg::CSR_DPC, csr_pkg::CSR_DMST,
                     csr_pkg::CSR_DICAWICS, csr_pkg::CSR_DICAD0, csr_pkg::CSR_DICAD0H,
                     csr_pkg::CSR_DICAD1, csr_pkg::CSR_DICAGO};
   tmr  = id inside {csr_pkg::CSR_MITCNT0, csr_pkg::CSR_MITCNT1, csr_pkg::CSR_MITB0,
                     csr_pkg::CSR_MITB1, csr_pkg::CSR_MITCTL0, csr_pkg::CSR_MITCTL1};
   fast = (id == csr_pkg::CSR_MEICPCT);
   legal = (id != csr_pkg::CSR_NONE) && (!dbg || halted) &&
           (!tmr || EXP_TIMER_EN != 0) && (!fast || EXP_FAST_INT_REDIRECT == 0) &&
           !(wen && ro);
   for (int i = 0; i < csr_pkg::PRESYNC_N; i++) begin
      if (id == csr_pkg::PRESYNC_LIST[i]) begin
         pre = !wen;
      end
   end
   for (int i = 0; i < csr_pkg::POSTSYNC_N; i++) begin
      if (id == csr_pkg::POSTSYNC_LIST[i]) begin
         post = 1'b1;
      end
   end
endfunction

`default_nettype wire
`endif

/* test/tb_csr_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_csr_decode;

   logic               clk;
   logic               reset;
   logic               csr_req;
   logic               csr_wen;
   logic               dbg_halted;
   csr_pkg::csr_addr_t csr_addr;
   logic               rsp_valid;
   logic               csr_legal;
   logic               presync;
   logic               postsync;
   csr_pkg::csr_id_e   rsp_id;

   logic               exp_valid;
   logic               exp_legal;
   logic               exp_pre;
   logic               exp_post;
   csr_pkg::csr_id_e   exp_id;

   int                 checks;
   int                 errors;
   int                 tests;
   int                 test_start;
   integer             seed;
   csr_pkg::csr_addr_t kept [$];

   `include "csr_expect.svh"

   csr_decode_unit i_dut (
      .clk        (clk),
      .reset      (reset),
      .csr_req    (csr_req),
      .csr_wen    (csr_wen),
      .dbg_halted (dbg_halted),
      .csr_addr   (csr_addr),
      .rsp_valid  (rsp_valid),
      .csr_legal  (csr_legal),
      .presync    (presync),
      .postsync   (postsync),
      .rsp_id     (rsp_id)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   initial begin
      reset = 1'b1;
      repeat (3) @(posedge clk);
      #2;
      reset = 1'b0;
   end

   task automatic check_value(input string name, input logic [11:0] got,
                              input logic [11:0] exp);
      checks++;
      assert (got === exp) else begin
         $display("Mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
         errors++;
      end
   endtask

   // ***********************************************************
   // compare process
   // ***********************************************************

   // expectation taken mid-cycle and checked after the next edge
   always begin
      @(negedge clk);
      exp_valid = csr_req;
      csr_expect(csr_addr, csr_wen, dbg_halted, exp_id, exp_legal, exp_pre, exp_post);
      if (!csr_req) begin
         exp_id    = csr_pkg::CSR_NONE;
         exp_legal = 1'b0;
         exp_pre   = 1'b0;
         exp_post  = 1'b0;
      end
      @(posedge clk);
      #1;
      if (reset) begin
         exp_valid = 1'b0;
         exp_id    = csr_pkg::CSR_NONE;
         exp_legal = 1'b0;
         exp_pre   = 1'b0;
         exp_post  = 1'b0;
      end
      check_value("rsp_valid", 12'(rsp_valid), 12'(exp_valid));
      check_value("rsp_id", rsp_id, exp_id);
      check_value("csr_legal", 12'(csr_legal), 12'(exp_legal));
      check_value("presync", 12'(presync), 12'(exp_pre));
      check_value("postsync", 12'(postsync), 12'(exp_post));
   end

   // ***********************************************************
   // stimulus
   // ***********************************************************

   task automatic drive_req(input csr_pkg::csr_addr_t addr, input logic wen,
                            input logic halted);
      @(posedge clk);
      #2;
      csr_req    = 1'b1;
      csr_addr   = addr;
      csr_wen    = wen;
      dbg_halted = halted;
   endtask

   task automatic drive_idle();
      @(posedge clk);
      #2;
      csr_req    = 1'b0;
      csr_addr   = '0;
      csr_wen    = 1'b0;
      dbg_halted = 1'b0;
   endtask

   task automatic sweep(input logic wen, input logic halted);
      foreach (kept[i]) begin
         drive_req(kept[i], wen, halted);
      end
   endtask

   task automatic finish_test(input string name);
      int cnt;
      cnt = 0;
      drive_idle();
      while (rsp_valid !== 1'b0 && cnt < 8) begin
         @(posedge clk);
         #1;
         cnt++;
      end
      if (rsp_valid !== 1'b0) begin
         $display("timeout: responses kept coming after the strobes stopped");
         $display("STATUS: FAIL");
         $finish;
      end else begin
         @(negedge clk);
         $display("test %-14s done, %0d errors", name, errors - test_start);
         tests++;
         test_start = errors;
      end
   endtask

   initial begin
      csr_pkg::csr_id_e e;
      int               cnt;
      int               idx;
      logic [31:0]      r;
      logic [31:0]      a;
      seed       = 32'h1b90;
      csr_req    = 1'b0;
      csr_wen    = 1'b0;
      dbg_halted = 1'b0;
      csr_addr   = '0;
      checks     = 0;
      errors     = 0;
      tests      = 0;
      test_start = 0;
      e = e.first();
      for (int i = 0; i < e.num(); i++) begin
         if (e != csr_pkg::CSR_NONE) begin
            kept.push_back(csr_pkg::csr_addr_t'(e));
         end
         e = e.next();
      end

      cnt = 0;
      while (reset !== 1'b0 && cnt < 20) begin
         @(posedge clk);
         cnt++;
      end
      if (reset !== 1'b0) begin
         $display("timeout: reset was never released");
         $display("STATUS: FAIL");
         $finish;
      end else begin
         repeat (4) drive_idle();
         finish_test("reset_idle");

         sweep(1'b0, 1'b0);
         finish_test("read_sweep");

         sweep(1'b1, 1'b0);
         finish_test("write_sweep");

         sweep(1'b0, 1'b1);
         sweep(1'b1, 1'b1);
         finish_test("debug_halted");

         // mix of known and arbitrary addresses
         repeat (500) begin
            r   = $random(seed);
            a   = $random(seed);
            idx = int'($unsigned(a) % kept.size());
            if (r[0]) begin
               drive_req(r[1] ? a[27:16] : kept[idx], r[2], r[3]);
            end else begin
               drive_idle();
            end
         end
         finish_test("random");

         $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
         if (errors == 0) begin
            $display("STATUS: PASS");
         end else begin
            $display("STATUS: FAIL");
         end
         $finish;
      end
   end

endmodule

`default_nettype wire

/* sim.f */
+incdir+include
logic/csr_pkg.sv
logic/csr_addr_decode.sv
logic/csr_access_check.sv
logic/csr_decode_unit.sv
test/csr_decode_sva.sv
test/tb_csr_decode.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_csr_decode
FILELIST  = sim.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
SRCS      = $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HDRS      = $(wildcard include/*.svh)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -q "STATUS: PASS"

clean:
	rm -rf $(OBJDIR)
